/* Bender.yml */
package:
  name: spi_stepper_top

sources:
  - hdl/spi_ctrl_pkg.sv
  - hdl/axil_reg_block.sv
  - hdl/spi_xfer_fsm.sv
  - hdl/sck_bit_timer.sv
  - hdl/spi_frame_shifter.sv
  - hdl/spi_stepper_top.sv
  - target: simulation
    files:
      - bench/tb_spi_stepper_top.sv

/* bench/tb_spi_stepper_top.sv */
// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
// directed testbench with one AXI4-Lite transaction in flight at a time
// miso loops back from mosi unless the slave model is switched on
// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
`timescale 1ns/100ps

module tb_spi_stepper_top;

  logic                    clk_25mhz;
  logic                    arst_n;
  logic                    miso;
  logic                    sck;
  logic                    mosi;
  spi_ctrl_pkg::axil_req_t axil_req;
  spi_ctrl_pkg::axil_rsp_t axil_rsp;
  spi_ctrl_pkg::cs_lines_t cs_n;

  int                      errors;
  int                      cycles;
  bit                      model_on;
  spi_ctrl_pkg::frame_t    model_pattern;
  spi_ctrl_pkg::frame_t    model_capture;
  int                      model_idx;
  int                      sck_rises;
  int                      sck_rises_cs;
  spi_ctrl_pkg::cs_lines_t cs_low_seen;
  spi_ctrl_pkg::cs_lines_t cs_prev;

  spi_stepper_top spi_stepper_top_i (.*);

  always #20 clk_25mhz = ~clk_25mhz;

  // four frames of about 700 cycles plus bus traffic and margin
  always @(posedge clk_25mhz) begin
    cycles++;
    if (cycles >= 6000) begin
      $display("timeout: the tests did not finish within %0d cycles", cycles);
      $display("Something failed");
      $finish;
    end
  end

  // miso drive and chip-select watch 2 ns after each rising edge
  always @(posedge clk_25mhz) begin
    #2;
    if (model_on) begin
      miso = (model_idx < 40) ? model_pattern[39 - model_idx] : 1'b0;
    end else begin
      miso = mosi;
    end
    cs_low_seen = cs_low_seen | ~cs_n;
    if (cs_n !== cs_prev) begin
      check_value("sck at cs_n change", 0, sck);
    end
    cs_prev = cs_n;
  end

  // slave model capture in mode 0
  always @(posedge sck) begin
    sck_rises++;
    if (cs_n != spi_ctrl_pkg::cs_lines_t'('1)) begin
      sck_rises_cs++;
    end
    model_capture = {model_capture[38:0], mosi};
  end

  always @(negedge sck) begin
    model_idx++;
  end

  task automatic check_value(input string name, input logic [63:0] expected,
                             input logic [63:0] actual);
    assert (actual === expected) else begin
      $display("ERR %0t %s expected %0h actual %0h", $time, name, expected, actual);
      errors++;
    end
  endtask

  task automatic axil_write(input spi_ctrl_pkg::axil_addr_t addr,
                            input spi_ctrl_pkg::axil_data_t data,
                            input spi_ctrl_pkg::axil_strb_t strb, input int resp_delay,
                            output spi_ctrl_pkg::axil_resp_t resp);
    axil_req.awaddr  = addr;
    axil_req.wdata   = data;
    axil_req.wstrb   = strb;
    axil_req.awvalid = 1'b1;
    axil_req.wvalid  = 1'b1;
    do begin
      @(posedge clk_25mhz);
      #2;
    end while (!axil_rsp.awready);
    check_value("wready", 1, axil_rsp.wready);
    @(posedge clk_25mhz);
    #2;
    axil_req.awvalid = 1'b0;
    axil_req.wvalid  = 1'b0;
    check_value("bvalid", 1, axil_rsp.bvalid);
    resp = axil_rsp.bresp;
    // same request offered again while the response is held
    repeat (resp_delay) begin
      axil_req.awvalid = 1'b1;
      axil_req.wvalid  = 1'b1;
      @(posedge clk_25mhz);
      #2;
      check_value("bvalid", 1, axil_rsp.bvalid);
      check_value("bresp", resp, axil_rsp.bresp);
      check_value("awready", 0, axil_rsp.awready);
      check_value("wready", 0, axil_rsp.wready);
    end
    axil_req.awvalid = 1'b0;
    axil_req.wvalid  = 1'b0;
    axil_req.bready  = 1'b1;
    @(posedge clk_25mhz);
    #2;
    axil_req.bready = 1'b0;
    check_value("bvalid", 0, axil_rsp.bvalid);
  endtask

  task automatic axil_read(input spi_ctrl_pkg::axil_addr_t addr, input int resp_delay,
                           output spi_ctrl_pkg::axil_data_t data,
                           output spi_ctrl_pkg::axil_resp_t resp);
    axil_req.araddr  = addr;
    axil_req.arvalid = 1'b1;
    do begin
      @(posedge clk_25mhz);
      #2;
    end while (!axil_rsp.arready);
    @(posedge clk_25mhz);
    #2;
    axil_req.arvalid = 1'b0;
    check_value("rvalid", 1, axil_rsp.rvalid);
    data = axil_rsp.rdata;
    resp = axil_rsp.rresp;
    repeat (resp_delay) begin
      axil_req.arvalid = 1'b1;
      @(posedge clk_25mhz);
      #2;
      check_value("rvalid", 1, axil_rsp.rvalid);
      check_value("rdata", data, axil_rsp.rdata);
      check_value("rresp", resp, axil_rsp.rresp);
      check_value("arready", 0, axil_rsp.arready);
    end
    axil_req.arvalid = 1'b0;
    axil_req.rready  = 1'b1;
    @(posedge clk_25mhz);
    #2;
    axil_req.rready = 1'b0;
    check_value("rvalid", 0, axil_rsp.rvalid);
  endtask

  task automatic read_expect(input spi_ctrl_pkg::axil_addr_t addr,
                             input spi_ctrl_pkg::axil_data_t exp_data,
                             input spi_ctrl_pkg::axil_resp_t exp_resp);
    spi_ctrl_pkg::axil_data_t data;
    spi_ctrl_pkg::axil_resp_t resp;
    axil_read(addr, 0, data, resp);
    check_value($sformatf("rdata at %0h", addr), exp_data, data);
    check_value($sformatf("rresp at %0h", addr), exp_resp, resp);
  endtask

  task automatic write_expect(input spi_ctrl_pkg::axil_addr_t addr,
                              input spi_ctrl_pkg::axil_data_t data,
                              input spi_ctrl_pkg::axil_strb_t strb,
                              input spi_ctrl_pkg::axil_resp_t exp_resp);
    spi_ctrl_pkg::axil_resp_t resp;
    axil_write(addr, data, strb, 0, resp);
    check_value($sformatf("bresp at %0h", addr), exp_resp, resp);
  endtask

  // bit set for each line expected low
  function automatic spi_ctrl_pkg::cs_lines_t cs_mask(input spi_ctrl_pkg::cs_sel_t idx);
    cs_mask = '0;
    if (idx < 12) begin
      cs_mask[idx] = 1'b1;
    end
  endfunction

  function automatic spi_ctrl_pkg::frame_t random_frame();
    return spi_ctrl_pkg::frame_t'({$urandom(), $urandom()});
  endfunction

  task automatic run_frame(input spi_ctrl_pkg::frame_t tx, input spi_ctrl_pkg::cs_sel_t idx,
                           input bit restart, output spi_ctrl_pkg::frame_t rx);
    spi_ctrl_pkg::axil_data_t data;
    spi_ctrl_pkg::axil_resp_t resp;
    axil_write(spi_ctrl_pkg::REG_TX_UPPER, spi_ctrl_pkg::axil_data_t'(tx[39:32]), 4'hF, 0,
               resp);
    axil_write(spi_ctrl_pkg::REG_TX_LOWER, tx[31:0], 4'hF, 0, resp);
    cs_low_seen  = '0;
    sck_rises    = 0;
    sck_rises_cs = 0;
    model_idx    = 0;
    axil_write(spi_ctrl_pkg::REG_CONFIG, spi_ctrl_pkg::axil_data_t'({idx, 1'b1}), 4'h1, 0,
               resp);
    read_expect(spi_ctrl_pkg::REG_STATUS, 0, spi_ctrl_pkg::RESP_OKAY);
    if (restart) begin
      while (sck_rises < 10) begin
        @(posedge clk_25mhz);
        #2;
      end
      // new TX data and a second start in the middle of the frame
      axil_write(spi_ctrl_pkg::REG_TX_LOWER, ~tx[31:0], 4'hF, 0, resp);
      axil_write(spi_ctrl_pkg::REG_CONFIG, spi_ctrl_pkg::axil_data_t'({idx, 1'b1}), 4'h1, 0,
                 resp);
    end
    do begin
      axil_read(spi_ctrl_pkg::REG_STATUS, 0, data, resp);
    end while (data[0] !== 1'b1);
    axil_read(spi_ctrl_pkg::REG_RX_UPPER, 0, data, resp);
    rx[39:32] = data[7:0];
    axil_read(spi_ctrl_pkg::REG_RX_LOWER, 0, data, resp);
    rx[31:0] = data;
    check_value("cs_n lines low", cs_mask(idx), cs_low_seen);
  endtask

  task automatic verify_reset_state();
    check_value("cs_n", spi_ctrl_pkg::cs_lines_t'('1), cs_n);
    check_value("sck", 0, sck);
    check_value("mosi", 0, mosi);
    check_value("awready", 0, axil_rsp.awready);
    check_value("wready", 0, axil_rsp.wready);
    check_value("arready", 0, axil_rsp.arready);
    check_value("bvalid", 0, axil_rsp.bvalid);
    check_value("rvalid", 0, axil_rsp.rvalid);
    read_expect(spi_ctrl_pkg::REG_STATUS, 1, spi_ctrl_pkg::RESP_OKAY);
    read_expect(spi_ctrl_pkg::REG_TX_UPPER, 0, spi_ctrl_pkg::RESP_OKAY);
    read_expect(spi_ctrl_pkg::REG_TX_LOWER, 0, spi_ctrl_pkg::RESP_OKAY);
    read_expect(spi_ctrl_pkg::REG_RX_UPPER, 0, spi_ctrl_pkg::RESP_OKAY);
    read_expect(spi_ctrl_pkg::REG_RX_LOWER, 0, spi_ctrl_pkg::RESP_OKAY);
    read_expect(spi_ctrl_pkg::REG_CONFIG, 0, spi_ctrl_pkg::RESP_OKAY);
  endtask

  task automatic register_access();
    spi_ctrl_pkg::axil_data_t upper;
    spi_ctrl_pkg::axil_data_t lower;
    spi_ctrl_pkg::axil_data_t cfg;
    spi_ctrl_pkg::axil_data_t part;
    upper = $urandom();
    lower = $urandom();
    cfg   = $urandom() & 32'hFFFF_FFFE;
    part  = $urandom();
    write_expect(spi_ctrl_pkg::REG_TX_UPPER, upper, 4'hF, spi_ctrl_pkg::RESP_OKAY);
    write_expect(spi_ctrl_pkg::REG_TX_LOWER, lower, 4'hF, spi_ctrl_pkg::RESP_OKAY);
    write_expect(spi_ctrl_pkg::REG_CONFIG, cfg, 4'hF, spi_ctrl_pkg::RESP_OKAY);
    read_expect(spi_ctrl_pkg::REG_TX_UPPER, upper & 32'hFF, spi_ctrl_pkg::RESP_OKAY);
    read_expect(spi_ctrl_pkg::REG_TX_LOWER, lower, spi_ctrl_pkg::RESP_OKAY);
    read_expect(spi_ctrl_pkg::REG_CONFIG, cfg & 32'h1E, spi_ctrl_pkg::RESP_OKAY);
    // bytes 0 and 2 only
    write_expect(spi_ctrl_pkg::REG_TX_LOWER, part, 4'b0101, spi_ctrl_pkg::RESP_OKAY);
    read_expect(spi_ctrl_pkg::REG_TX_LOWER, (lower & 32'hFF00_FF00) | (part & 32'h00FF_00FF),
                spi_ctrl_pkg::RESP_OKAY);
    write_expect(8'h18, part, 4'hF, spi_ctrl_pkg::RESP_SLVERR);
    read_expect(8'h18, 0, spi_ctrl_pkg::RESP_SLVERR);
    write_expect(spi_ctrl_pkg::REG_RX_LOWER, part, 4'hF, spi_ctrl_pkg::RESP_SLVERR);
    read_expect(spi_ctrl_pkg::REG_RX_LOWER, 0, spi_ctrl_pkg::RESP_OKAY);
    write_expect(spi_ctrl_pkg::REG_STATUS, 0, 4'hF, spi_ctrl_pkg::RESP_SLVERR);
    read_expect(spi_ctrl_pkg::REG_STATUS, 1, spi_ctrl_pkg::RESP_OKAY);
  endtask

  task automatic loopback_frame();
    spi_ctrl_pkg::frame_t tx;
    spi_ctrl_pkg::frame_t rx;
    tx = random_frame();
    run_frame(tx, spi_ctrl_pkg::cs_sel_t'($urandom() % 12), 1'b0, rx);
    check_value("rx_frame loopback", tx, rx);
  endtask

  task automatic slave_model_frame();
    spi_ctrl_pkg::frame_t tx;
    spi_ctrl_pkg::frame_t rx;
    tx            = random_frame();
    model_pattern = random_frame();
    model_on      = 1'b1;
    run_frame(tx, spi_ctrl_pkg::cs_sel_t'($urandom() % 12), 1'b0, rx);
    model_on = 1'b0;
    check_value("captured mosi", tx, model_capture);
    check_value("rx_frame model", model_pattern, rx);
    check_value("sck rises with cs_n low", 40, sck_rises_cs);
  endtask

  task automatic unselected_and_busy();
    spi_ctrl_pkg::frame_t tx;
    spi_ctrl_pkg::frame_t rx;
    tx = random_frame();
    run_frame(tx, 4'd13, 1'b0, rx);
    check_value("rx_frame index 13", tx, rx);
    check_value("sck rises index 13", 40, sck_rises);
    tx = random_frame();
    run_frame(tx, 4'd13, 1'b1, rx);
    check_value("rx_frame after busy start", tx, rx);
    read_expect(spi_ctrl_pkg::REG_STATUS, 1, spi_ctrl_pkg::RESP_OKAY);
    check_value("sck rises after busy start", 40, sck_rises);
  endtask

  task automatic back_pressure();
    spi_ctrl_pkg::axil_data_t value;
    spi_ctrl_pkg::axil_data_t data;
    spi_ctrl_pkg::axil_resp_t resp;
    value = $urandom();
    axil_write(spi_ctrl_pkg::REG_TX_LOWER, value, 4'hF, 6, resp);
    check_value("bresp held", spi_ctrl_pkg::RESP_OKAY, resp);
    axil_read(spi_ctrl_pkg::REG_TX_LOWER, 6, data, resp);
    check_value("rdata held", value, data);
    check_value("rresp held", spi_ctrl_pkg::RESP_OKAY, resp);
  endtask

  initial begin
    clk_25mhz     = 1'b0;
    arst_n        = 1'b0;
    miso          = 1'b0;
    axil_req      = '0;
    errors        = 0;
    cycles        = 0;
    model_on      = 1'b0;
    model_pattern = '0;
    model_capture = '0;
    model_idx     = 0;
    sck_rises     = 0;
    sck_rises_cs  = 0;
    cs_low_seen   = '0;
    cs_prev       = '1;
    void'($urandom(97));
    repeat (8) @(posedge clk_25mhz);
    #2;
    arst_n = 1'b1;
    verify_reset_state();
    register_access();
    loopback_frame();
    slave_model_frame();
    unselected_and_busy();
    back_pressure();
    $display("checks failed: %0d", errors);
    if (errors == 0) begin
      $display("Everything OK");
    end else begin
      $display("Something failed");
    end
    $finish;
  end

endmodule

/* hdl/axil_reg_block.sv */
// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
// AXI4-Lite slave, single outstanding write and read, exact address match
// start is only issued while the engine reports ready
// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
`timescale 1ns/100ps

module axil_reg_block (
  input  logic                    clk_25mhz,
  input  logic                    arst_n,
  input  spi_ctrl_pkg::axil_req_t axil_req,
  output spi_ctrl_pkg::axil_rsp_t axil_rsp,
  input  spi_ctrl_pkg::frame_t    rx_frame,
  input  logic                    ready,
  output spi_ctrl_pkg::spi_ctrl_t spi_ctrl
);

  // one ready serves both aw and w
  logic                     awready;
  logic                     bvalid;
  spi_ctrl_pkg::axil_resp_t bresp;
  logic                     arready;
  logic                     rvalid;
  spi_ctrl_pkg::axil_data_t rdata;
  spi_ctrl_pkg::axil_resp_t rresp;

  spi_ctrl_pkg::frame_t     tx_frame;
  spi_ctrl_pkg::cs_sel_t    cs_sel;
  logic                     start;

  logic                     wr_fire;
  logic                     rd_fire;
  spi_ctrl_pkg::axil_data_t rd_data;
  spi_ctrl_pkg::axil_resp_t rd_resp;

  assign wr_fire = awready && axil_req.awvalid && axil_req.wvalid;
  assign rd_fire = arready && axil_req.arvalid;

  // write channel and register updates
  always_ff @(posedge clk_25mhz or negedge arst_n) begin
    if (!arst_n) begin
      awready  <= 1'b0;
      bvalid   <= 1'b0;
      bresp    <= spi_ctrl_pkg::RESP_OKAY;
      tx_frame <= '0;
      cs_sel   <= '0;
      start    <= 1'b0;
    end else begin
      awready <= axil_req.awvalid && axil_req.wvalid && !bvalid && !awready;
      start   <= 1'b0;
      if (bvalid && axil_req.bready) begin
        bvalid <= 1'b0;
      end
      if (wr_fire) begin
        bvalid <= 1'b1;
        bresp  <= spi_ctrl_pkg::RESP_OKAY;
        case (axil_req.awaddr)
          spi_ctrl_pkg::REG_TX_UPPER: begin
            if (axil_req.wstrb[0]) begin
              tx_frame[spi_ctrl_pkg::FRAME_BITS-1:spi_ctrl_pkg::DATA_BITS] <=
                axil_req.wdata[spi_ctrl_pkg::FRAME_BITS-spi_ctrl_pkg::DATA_BITS-1:0];
            end
          end
          spi_ctrl_pkg::REG_TX_LOWER: begin
            for (int i = 0; i < spi_ctrl_pkg::STRB_BITS; i++) begin
              if (axil_req.wstrb[i]) begin
                tx_frame[i*8 +: 8] <= axil_req.wdata[i*8 +: 8];
              end
            end
          end
          spi_ctrl_pkg::REG_CONFIG: begin
            if (axil_req.wstrb[0]) begin
              cs_sel <= axil_req.wdata[spi_ctrl_pkg::CS_SEL_BITS:1];
              // start while busy is dropped
              start  <= axil_req.wdata[0] && ready;
            end
          end
          default: bresp <= spi_ctrl_pkg::RESP_SLVERR;
        endcase
      end
    end
  end

  // read channel handshake
  always_ff @(posedge clk_25mhz or negedge arst_n) begin
    if (!arst_n) begin
      arready <= 1'b0;
      rvalid  <= 1'b0;
    end else begin
      arready <= axil_req.arvalid && !rvalid && !arready;
      if (rvalid && axil_req.rready) begin
        rvalid <= 1'b0;
      end
      if (rd_fire) begin
        rvalid <= 1'b1;
      end
    end
  end

  // read data held until the next accepted read
  always_ff @(posedge clk_25mhz) begin
    if (rd_fire) begin
      rdata <= rd_data;
      rresp <= rd_resp;
    end
  end

  always_comb begin
    rd_data = '0;
    rd_resp = spi_ctrl_pkg::RESP_OKAY;
    case (axil_req.araddr)
      spi_ctrl_pkg::REG_TX_UPPER:
        rd_data = spi_ctrl_pkg::axil_data_t'(tx_frame[spi_ctrl_pkg::FRAME_BITS-1:
                                                        spi_ctrl_pkg::DATA_BITS]);
      spi_ctrl_pkg::REG_TX_LOWER: rd_data = tx_frame[spi_ctrl_pkg::DATA_BITS-1:0];
      spi_ctrl_pkg::REG_RX_UPPER:
        rd_data = spi_ctrl_pkg::axil_data_t'(rx_frame[spi_ctrl_pkg::FRAME_BITS-1:
                                                        spi_ctrl_pkg::DATA_BITS]);
      spi_ctrl_pkg::REG_RX_LOWER: rd_data = rx_frame[spi_ctrl_pkg::DATA_BITS-1:0];
      // start bit always reads back as zero
      spi_ctrl_pkg::REG_CONFIG:   rd_data = spi_ctrl_pkg::axil_data_t'({cs_sel, 1'b0});
      spi_ctrl_pkg::REG_STATUS:   rd_data = spi_ctrl_pkg::axil_data_t'(ready);
      default:                    rd_resp = spi_ctrl_pkg::RESP_SLVERR;
    endcase
  end

  assign axil_rsp = '{awready: awready, wready: awready, bresp: bresp, bvalid: bvalid,
                      arready: arready, rdata: rdata, rresp: rresp, rvalid: rvalid};

  assign spi_ctrl = '{tx_frame: tx_frame, cs_sel: cs_sel, start: start};

endmodule

/* hdl/sck_bit_timer.sv */
// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
// half-period and bit counters for the SPI engine, idle between frames
// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
`timescale 1ns/100ps

module sck_bit_timer (
  input  logic                      clk_25mhz,
  input  logic                      arst_n,
  input  spi_ctrl_pkg::xfer_state_t state,
  output logic                      half_tick,
  output logic                      sck_phase,
  output logic                      last_bit
);

  logic [spi_ctrl_pkg::HALF_CNT_BITS-1:0] half_cnt;
  logic [spi_ctrl_pkg::BIT_CNT_BITS-1:0]  bit_cnt;

  assign half_tick = (state != spi_ctrl_pkg::IDLE) &&
                     (half_cnt == spi_ctrl_pkg::HALF_CNT_BITS'(spi_ctrl_pkg::SCK_HALF_CLKS - 1));
  assign last_bit  = (bit_cnt == spi_ctrl_pkg::BIT_CNT_BITS'(spi_ctrl_pkg::FRAME_BITS - 1));

  always_ff @(posedge clk_25mhz or negedge arst_n) begin
    if (!arst_n) begin
      half_cnt  <= '0;
      bit_cnt   <= '0;
      sck_phase <= 1'b0;
    end else if (state == spi_ctrl_pkg::IDLE) begin
      half_cnt  <= '0;
      bit_cnt   <= '0;
      sck_phase <= 1'b0;
    end else begin
      half_cnt <= half_tick ? '0 : half_cnt + 1'b1;
      if (state == spi_ctrl_pkg::SHIFT && half_tick) begin
        sck_phase <= ~sck_phase;
        // a bit is complete at the end of the high half
        if (sck_phase) begin
          bit_cnt <= bit_cnt + 1'b1;
        end
      end
    end
  end

endmodule

/* hdl/spi_ctrl_pkg.sv */
// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
// widths, register map and types of the SPI stepper controller
// SCK ratio is fixed here, there is no runtime divider
// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
package spi_ctrl_pkg;

  localparam int FRAME_BITS    = 40;
  localparam int CS_LINES      = 12;
  localparam int CS_SEL_BITS   = 4;
  localparam int SCK_HALF_CLKS = 8;
  localparam int ADDR_BITS     = 8;
  localparam int DATA_BITS     = 32;
  localparam int STRB_BITS     = DATA_BITS / 8;
  localparam int HALF_CNT_BITS = $clog2(SCK_HALF_CLKS);
  // one spare count so the bit counter can pass the last bit
  localparam int BIT_CNT_BITS  = $clog2(FRAME_BITS + 1);

  typedef logic [FRAME_BITS-1:0]  frame_t;
  typedef logic [CS_SEL_BITS-1:0] cs_sel_t;
  typedef logic [CS_LINES-1:0]    cs_lines_t;
  typedef logic [ADDR_BITS-1:0]   axil_addr_t;
  typedef logic [DATA_BITS-1:0]   axil_data_t;
  typedef logic [STRB_BITS-1:0]   axil_strb_t;
  typedef logic [1:0]             axil_resp_t;

  // byte addresses, word aligned
  localparam axil_addr_t REG_TX_UPPER = 8'h00;
  localparam axil_addr_t REG_TX_LOWER = 8'h04;
  localparam axil_addr_t REG_RX_UPPER = 8'h08;
  localparam axil_addr_t REG_RX_LOWER = 8'h0C;
  localparam axil_addr_t REG_CONFIG   = 8'h10;
  localparam axil_addr_t REG_STATUS   = 8'h14;

  localparam axil_resp_t RESP_OKAY   = 2'b00;
  localparam axil_resp_t RESP_SLVERR = 2'b10;

  typedef struct packed {
    axil_addr_t awaddr;
    logic       awvalid;
    axil_data_t wdata;
    axil_strb_t wstrb;
    logic       wvalid;
    logic       bready;
    axil_addr_t araddr;
    logic       arvalid;
    logic       rready;
  } axil_req_t;

  typedef struct packed {
    logic       awready;
    logic       wready;
    axil_resp_t bresp;
    logic       bvalid;
    logic       arready;
    axil_data_t rdata;
    axil_resp_t rresp;
    logic       rvalid;
  } axil_rsp_t;

  // start is a single-cycle pulse
  typedef struct packed {
    frame_t  tx_frame;
    cs_sel_t cs_sel;
    logic    start;
  } spi_ctrl_t;

  typedef enum logic [1:0] {
    IDLE,
    SELECT,
    SHIFT,
    FINISH
  } xfer_state_t;

endpackage

/* hdl/spi_frame_shifter.sv */
// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
// mode 0 shift datapath, MSB first, index 12 to 15 selects no driver
// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
`timescale 1ns/100ps

module spi_frame_shifter (
  input  logic                      clk_25mhz,
  input  logic                      arst_n,
  input  spi_ctrl_pkg::spi_ctrl_t   spi_ctrl,
  input  spi_ctrl_pkg::xfer_state_t state,
  input  logic                      half_tick,
  input  logic                      sck_phase,
  input  logic                      miso,
  output logic                      sck,
  output logic                      mosi,
  output spi_ctrl_pkg::cs_lines_t   cs_n,
  output spi_ctrl_pkg::frame_t      rx_frame
);

  spi_ctrl_pkg::frame_t tx_shift;
  spi_ctrl_pkg::frame_t rx_shift;

  // active low one-hot, all high when out of range
  function automatic spi_ctrl_pkg::cs_lines_t cs_decode(input spi_ctrl_pkg::cs_sel_t sel);
    spi_ctrl_pkg::cs_lines_t lines;
    for (int i = 0; i < spi_ctrl_pkg::CS_LINES; i++) begin
      lines[i] = (sel != spi_ctrl_pkg::cs_sel_t'(i));
    end
    return lines;
  endfunction

  always_ff @(posedge clk_25mhz or negedge arst_n) begin
    if (!arst_n) begin
      tx_shift <= '0;
      rx_shift <= '0;
      sck      <= 1'b0;
      cs_n     <= '1;
    end else begin
      // frame and select latched once, register writes cannot disturb them
      if (spi_ctrl.start) begin
        tx_shift <= spi_ctrl.tx_frame;
        cs_n     <= cs_decode(spi_ctrl.cs_sel);
      end else if (state == spi_ctrl_pkg::FINISH && half_tick) begin
        cs_n <= '1;
      end
      if (state == spi_ctrl_pkg::SHIFT && half_tick) begin
        sck <= ~sck_phase;
        if (sck_phase) begin
          // falling edge, present next bit
          tx_shift <= {tx_shift[spi_ctrl_pkg::FRAME_BITS-2:0], 1'b0};
        end else begin
          // rising edge, sample
          rx_shift <= {rx_shift[spi_ctrl_pkg::FRAME_BITS-2:0], miso};
        end
      end
    end
  end

  assign mosi     = tx_shift[spi_ctrl_pkg::FRAME_BITS-1];
  assign rx_frame = rx_shift;

endmodule

/* hdl/spi_stepper_top.sv */
// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
// SPI peripheral of the stepper controller, AXI4-Lite register access
// arst_n is taken as already clean, no debounce or synchronizer here
// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
`timescale 1ns/100ps

module spi_stepper_top (
  input  logic                    clk_25mhz,
  input  logic                    arst_n,
  input  spi_ctrl_pkg::axil_req_t axil_req,
  output spi_ctrl_pkg::axil_rsp_t axil_rsp,
  input  logic                    miso,
  output logic                    sck,
  output logic                    mosi,
  output spi_ctrl_pkg::cs_lines_t cs_n
);

  spi_ctrl_pkg::spi_ctrl_t   spi_ctrl;
  spi_ctrl_pkg::frame_t      rx_frame;
  spi_ctrl_pkg::xfer_state_t state;
  logic                      ready;
  logic                      half_tick;
  logic                      sck_phase;
  logic                      last_bit;

  axil_reg_block axil_reg_block_i (
    .clk_25mhz(clk_25mhz),
    .arst_n   (arst_n),
    .axil_req (axil_req),
    .axil_rsp (axil_rsp),
    .rx_frame (rx_frame),
    .ready    (ready),
    .spi_ctrl (spi_ctrl)
  );

  spi_xfer_fsm spi_xfer_fsm_i (
    .clk_25mhz(clk_25mhz),
    .arst_n   (arst_n),
    .start    (spi_ctrl.start),
    .half_tick(half_tick),
    .last_bit (last_bit),
    .sck_phase(sck_phase),
    .state    (state),
    .ready    (ready)
  );

  sck_bit_timer sck_bit_timer_i (
    .clk_25mhz(clk_25mhz),
    .arst_n   (arst_n),
    .state    (state),
    .half_tick(half_tick),
    .sck_phase(sck_phase),
    .last_bit (last_bit)
  );

  spi_frame_shifter spi_frame_shifter_i (
    .clk_25mhz(clk_25mhz),
    .arst_n   (arst_n),
    .spi_ctrl (spi_ctrl),
    .state    (state),
    .half_tick(half_tick),
    .sck_phase(sck_phase),
    .miso     (miso),
    .sck      (sck),
    .mosi     (mosi),
    .cs_n     (cs_n),
    .rx_frame (rx_frame)
  );

endmodule

/* hdl/spi_xfer_fsm.sv */
// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
// frame sequencer, one frame per start pulse
// start is expected only while ready is high
// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
`timescale 1ns/100ps

module spi_xfer_fsm (
  input  logic                      clk_25mhz,
  input  logic                      arst_n,
  input  logic                      start,
  input  logic                      half_tick,
  input  logic                      last_bit,
  input  logic                      sck_phase,
  output spi_ctrl_pkg::xfer_state_t state,
  output logic                      ready
);

  spi_ctrl_pkg::xfer_state_t next_state;

  always_comb begin
    next_state = state;
    case (state)
      spi_ctrl_pkg::IDLE: begin
        if (start) begin
          next_state = spi_ctrl_pkg::SELECT;
        end
      end
      // chip select setup time before the first edge
      spi_ctrl_pkg::SELECT: begin
        if (half_tick) begin
          next_state = spi_ctrl_pkg::SHIFT;
        end
      end
      // leave on the falling edge that closes the last bit
      spi_ctrl_pkg::SHIFT: begin
        if (half_tick && sck_phase && last_bit) begin
          next_state = spi_ctrl_pkg::FINISH;
        end
      end
      // hold time after the last edge
      spi_ctrl_pkg::FINISH: begin
        if (half_tick) begin
          next_state = spi_ctrl_pkg::IDLE;
        end
      end
      default: next_state = spi_ctrl_pkg::IDLE;
    endcase
  end

  always_ff @(posedge clk_25mhz or negedge arst_n) begin
    if (!arst_n) begin
      state <= spi_ctrl_pkg::IDLE;
      ready <= 1'b1;
    end else begin
      state <= next_state;
      // ready follows the state register without lag
      ready <= (next_state == spi_ctrl_pkg::IDLE);
    end
  end

endmodule

/* spi_stepper_top.f */
hdl/spi_ctrl_pkg.sv
hdl/axil_reg_block.sv
hdl/spi_xfer_fsm.sv
hdl/sck_bit_timer.sv
hdl/spi_frame_shifter.sv
hdl/spi_stepper_top.sv
bench/tb_spi_stepper_top.sv
